//--- corr_pkg.sv
// Shared widths, types and the baseline count for the correlator, imported by the design and testbench
package corr_pkg;

	// ========================================
	// Delay line selection
	// ========================================

	localparam int DELAY_BITS = 3; // Bits of a per-input tap selection
	localparam int MAX_DELAY = 7; // Deepest in-phase tap in strobes

	typedef logic [DELAY_BITS-1:0] delay_sel_t;

	// ========================================
	// Integration
	// ========================================

	localparam int INTEG_BITS = 16;

	typedef logic [INTEG_BITS-1:0] integ_len_t; // Sample strobes per integration

	// ========================================
	// Baselines
	// ========================================

	// One baseline per unordered pair of inputs
	function automatic int num_baselines(input int num_inputs);
		int count;
		count = num_inputs * (num_inputs - 1) / 2;
		return count;
	endfunction

endpackage

//--- sample_bus_if.sv
// Delayed sample bus from the delay bank to the accumulator array, one bit per input per strobe
`timescale 1ns/1ps

interface sample_bus_if #(
	parameter int NUM_INPUTS = 4
) ();

	logic strobe; // One cycle per accepted sample
	logic [NUM_INPUTS-1:0] inphase; // Tap at the selected delay
	logic [NUM_INPUTS-1:0] quadrature; // Tap at the selected delay plus the quadrature lag
	logic frame_end; // Marks the last sample of an integration

	modport source (
		output strobe,
		output inphase,
		output quadrature,
		output frame_end
	);

	modport sink (
		input strobe,
		input inphase,
		input quadrature,
		input frame_end
	);

endinterface

//--- frame_if.sv
// Snapshot frame from the accumulator array to the serializer, with the serializer's busy flag back
`timescale 1ns/1ps

interface frame_if import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4,
	parameter int RESOLUTION = 12
) ();

	localparam int NB = num_baselines(NUM_INPUTS);

	logic [2*NB-1:0][RESOLUTION-1:0] sums; // Real at 2k and imaginary at 2k+1 for baseline k
	logic [NB-1:0] overflow;
	logic valid; // Pulses when a new snapshot is loaded
	logic busy; // Serializer is still sending

	modport source (
		output sums,
		output overflow,
		output valid,
		input busy
	);

	modport sink (
		input sums,
		input overflow,
		input valid,
		output busy
	);

endinterface

//--- sample_delay_bank.sv
// Input side of the correlator: per-input delay lines with selectable taps and the integration counter
`timescale 1ns/1ps

module sample_delay_bank import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4,
	parameter int QUAD_LAG = 2
) (
	input logic pllclk,
	input logic reset,
	input logic [NUM_INPUTS-1:0] samples,
	input logic sample_strobe,
	input delay_sel_t [NUM_INPUTS-1:0] delay_sel,
	input integ_len_t integ_len,
	sample_bus_if.source bus
);

	localparam int HIST_LEN = MAX_DELAY + QUAD_LAG; // Past samples kept besides the current one

	logic [NUM_INPUTS-1:0][HIST_LEN-1:0] hist; // Bit 0 is the previous sample
	logic [NUM_INPUTS-1:0][HIST_LEN:0] taps; // Bit j is the sample from j strobes earlier
	integ_len_t strobe_cnt;
	integ_len_t len_q;
	integ_len_t eff_len;
	integ_len_t cur_len;
	logic last_strobe;

	// ========================================
	// Delay lines
	// ========================================

	always_comb begin
		for (int k = 0; k < NUM_INPUTS; k++) begin
			taps[k] = {hist[k], samples[k]};
		end
	end

	always_ff @(posedge pllclk) begin
		if (sample_strobe) begin
			for (int k = 0; k < NUM_INPUTS; k++) begin
				bus.inphase[k] <= taps[k][delay_sel[k]];
				bus.quadrature[k] <= taps[k][delay_sel[k] + QUAD_LAG];
			end
		end
	end

	// ========================================
	// Integration counter
	// ========================================

	always_comb begin
		eff_len = (integ_len == '0) ? integ_len_t'(1) : integ_len; // Zero length acts as one
		cur_len = (strobe_cnt == '0) ? eff_len : len_q; // A new frame uses the live length
		last_strobe = ((strobe_cnt + integ_len_t'(1)) == cur_len);
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			hist <= '0; // History reads as zero until filled
			strobe_cnt <= '0;
			len_q <= '0;
			bus.strobe <= 1'b0;
			bus.frame_end <= 1'b0;
		end else begin
			bus.strobe <= sample_strobe;
			bus.frame_end <= sample_strobe && last_strobe;
			if (sample_strobe) begin
				for (int k = 0; k < NUM_INPUTS; k++) begin
					hist[k] <= taps[k][HIST_LEN-1:0];
				end
				if (strobe_cnt == '0) begin
					len_q <= eff_len;
				end
				strobe_cnt <= last_strobe ? '0 : strobe_cnt + integ_len_t'(1);
			end
		end
	end

	// The accumulators need a free cycle between strobes
	strobe_spacing: assert property (@(posedge pllclk) disable iff (!reset)
		sample_strobe |=> !sample_strobe);

endmodule

//--- baseline_accumulator.sv
// Saturating real and imaginary agreement counters for one baseline of the correlator array
`timescale 1ns/1ps

module baseline_accumulator #(
	parameter int RESOLUTION = 12
) (
	input logic pllclk,
	input logic reset,
	input logic strobe,
	input logic frame_end,
	input logic sample_a,
	input logic sample_b,
	input logic sample_b_quad,
	output logic [RESOLUTION-1:0] sum_re,
	output logic [RESOLUTION-1:0] sum_im,
	output logic overflow,
	output logic [RESOLUTION-1:0] total_re,
	output logic [RESOLUTION-1:0] total_im,
	output logic total_overflow
);

	typedef logic [RESOLUTION-1:0] count_t;

	localparam count_t MAX_COUNT = '1;

	logic inc_re;
	logic inc_im;
	logic sat_re;
	logic sat_im;

	always_comb begin
		inc_re = strobe && (sample_a == sample_b);
		inc_im = strobe && (sample_a == sample_b_quad);
		sat_re = (sum_re == MAX_COUNT);
		sat_im = (sum_im == MAX_COUNT);
		total_re = (inc_re && !sat_re) ? sum_re + count_t'(1) : sum_re;
		total_im = (inc_im && !sat_im) ? sum_im + count_t'(1) : sum_im;
		// An agreement lost at full scale marks the frame as overflowed
		total_overflow = overflow || (inc_re && sat_re) || (inc_im && sat_im);
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			sum_re <= '0;
			sum_im <= '0;
			overflow <= 1'b0;
		end else if (strobe && frame_end) begin
			sum_re <= '0; // Totals leave through the snapshot
			sum_im <= '0;
			overflow <= 1'b0;
		end else begin
			sum_re <= total_re;
			sum_im <= total_im;
			overflow <= total_overflow;
		end
	end

	count_monotonic: assert property (@(posedge pllclk) disable iff (!reset)
		!frame_end |=> (sum_re >= $past(sum_re)) && (sum_im >= $past(sum_im)));

endmodule

//--- correlator_array.sv
// Processing part of the correlator: one accumulator per baseline and the frame snapshot register
`timescale 1ns/1ps

module correlator_array import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4,
	parameter int RESOLUTION = 12
) (
	input logic pllclk,
	input logic reset,
	sample_bus_if.sink bus,
	frame_if.source fr
);

	localparam int NB = num_baselines(NUM_INPUTS);

	logic [NB-1:0][RESOLUTION-1:0] tot_re;
	logic [NB-1:0][RESOLUTION-1:0] tot_im;
	logic [NB-1:0] tot_ovf;

	// ========================================
	// Baselines in pair order (0,1) (0,2) ... (1,2) ...
	// ========================================

	for (genvar a = 0; a < NUM_INPUTS - 1; a++) begin : g_row
		for (genvar b = a + 1; b < NUM_INPUTS; b++) begin : g_col
			localparam int K = a * NUM_INPUTS - a * (a + 1) / 2 + (b - a - 1);

			baseline_accumulator #(
				.RESOLUTION(RESOLUTION)
			) u_acc (
				.pllclk(pllclk),
				.reset(reset),
				.strobe(bus.strobe),
				.frame_end(bus.frame_end),
				.sample_a(bus.inphase[a]),
				.sample_b(bus.inphase[b]),
				.sample_b_quad(bus.quadrature[b]),
				.sum_re(),
				.sum_im(),
				.overflow(),
				.total_re(tot_re[K]),
				.total_im(tot_im[K]),
				.total_overflow(tot_ovf[K])
			);
		end
	end

	// ========================================
	// Snapshot
	// ========================================

	always_ff @(posedge pllclk) begin
		if (bus.strobe && bus.frame_end) begin
			for (int k = 0; k < NB; k++) begin
				fr.sums[2*k] <= tot_re[k];
				fr.sums[2*k+1] <= tot_im[k];
			end
			fr.overflow <= tot_ovf;
		end
	end

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			fr.valid <= 1'b0;
		end else begin
			fr.valid <= bus.strobe && bus.frame_end; // Lands with the snapshot
		end
	end

endmodule

//--- frame_serializer.sv
// Output side of the correlator: sends each frame word by word over four-phase req/ack
`timescale 1ns/1ps

module frame_serializer import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4,
	parameter int RESOLUTION = 12
) (
	input logic pllclk,
	input logic reset,
	frame_if.sink fr,
	input logic out_ack,
	output logic out_req,
	output logic [RESOLUTION-1:0] out_data,
	output logic frame_dropped
);

	localparam int NB = num_baselines(NUM_INPUTS);
	localparam int NUM_WORDS = 2 * NB + 1; // Sums then one status word
	localparam int IDX_BITS = $clog2(NUM_WORDS);

	typedef logic [RESOLUTION-1:0] word_t;
	typedef enum logic [1:0] {
		idle,
		send,
		wait_ack_high,
		wait_ack_low
	} ser_state_t;

	ser_state_t state;
	word_t [NUM_WORDS-1:0] word_buf;
	logic [IDX_BITS-1:0] word_idx;

	assign fr.busy = (state != idle);

	// ========================================
	// Handshake FSM
	// ========================================

	always_ff @(posedge pllclk) begin
		if (!reset) begin
			state <= idle;
			out_req <= 1'b0;
			word_idx <= '0;
			frame_dropped <= 1'b0;
		end else begin
			frame_dropped <= fr.valid && fr.busy; // Snapshot lost while sending
			case (state)
				idle: begin
					if (fr.valid) begin
						out_req <= 1'b1; // First word goes out with the capture
						word_idx <= '0;
						state <= wait_ack_high;
					end
				end
				send: begin
					out_req <= 1'b1;
					state <= wait_ack_high;
				end
				wait_ack_high: begin
					if (out_ack) begin
						out_req <= 1'b0;
						state <= wait_ack_low;
					end
				end
				wait_ack_low: begin
					if (!out_ack) begin
						if (word_idx == IDX_BITS'(NUM_WORDS - 1)) begin
							state <= idle;
						end else begin
							word_idx <= word_idx + 1'b1;
							state <= send;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Data only changes while out_req is low
	always_ff @(posedge pllclk) begin
		if (state == idle && fr.valid) begin
			word_buf <= {word_t'(fr.overflow), fr.sums};
			out_data <= fr.sums[0];
		end else if (state == send) begin
			out_data <= word_buf[word_idx];
		end
	end

	data_stable: assert property (@(posedge pllclk) disable iff (!reset)
		out_req |=> !out_req || $stable(out_data));

endmodule

//--- correlator_top.sv
// RTL top level of the correlator: plain ports in, interfaces built here to join the three parts
`timescale 1ns/1ps

module correlator_top import corr_pkg::*; #(
	parameter int NUM_INPUTS = 4,
	parameter int RESOLUTION = 12,
	parameter int QUAD_LAG = 2
) (
	input logic pllclk,
	input logic reset,
	input logic [NUM_INPUTS-1:0] samples,
	input logic sample_strobe,
	input delay_sel_t [NUM_INPUTS-1:0] delay_sel,
	input integ_len_t integ_len,
	input logic out_ack,
	output logic out_req,
	output logic [RESOLUTION-1:0] out_data,
	output logic frame_dropped
);

	sample_bus_if #(.NUM_INPUTS(NUM_INPUTS)) sample_bus ();
	frame_if #(.NUM_INPUTS(NUM_INPUTS), .RESOLUTION(RESOLUTION)) frame ();

	sample_delay_bank #(
		.NUM_INPUTS(NUM_INPUTS),
		.QUAD_LAG(QUAD_LAG)
	) u_delay_bank (
		.pllclk(pllclk),
		.reset(reset),
		.samples(samples),
		.sample_strobe(sample_strobe),
		.delay_sel(delay_sel),
		.integ_len(integ_len),
		.bus(sample_bus)
	);

	correlator_array #(
		.NUM_INPUTS(NUM_INPUTS),
		.RESOLUTION(RESOLUTION)
	) u_array (
		.pllclk(pllclk),
		.reset(reset),
		.bus(sample_bus),
		.fr(frame)
	);

	frame_serializer #(
		.NUM_INPUTS(NUM_INPUTS),
		.RESOLUTION(RESOLUTION)
	) u_serializer (
		.pllclk(pllclk),
		.reset(reset),
		.fr(frame),
		.out_ack(out_ack),
		.out_req(out_req),
		.out_data(out_data),
		.frame_dropped(frame_dropped)
	);

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset source for the correlator, instantiated once by the testbench top
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic pllclk,
	output logic reset
);

	initial begin
		pllclk = 1'b0;
		forever #(PERIOD_NS / 2) pllclk = ~pllclk;
	end

	initial begin
		reset = 1'b0; // Active low, held through the first cycles
		repeat (RESET_CYCLES) @(posedge pllclk);
		reset <= 1'b1;
	end

endmodule

//--- correlator_tb.sv
// Directed testbench for the correlator with a reference model, output receiver and watchdog
`timescale 1ns/1ps

module correlator_tb import corr_pkg::*; ();

	localparam int NUM_INPUTS = 4;
	localparam int RESOLUTION = 8;
	localparam int QUAD_LAG = 2;
	localparam int NB = num_baselines(NUM_INPUTS);
	localparam int NUM_WORDS = 2 * NB + 1;
	localparam int MAX_COUNT = (1 << RESOLUTION) - 1;
	localparam int STROBE_GAP = 3;
	localparam int TOTAL_STROBES = 20 + 150 + 40 + 320 + 160;
	localparam int SLACK_CYCLES = 6000;
	localparam int WORD_TIMEOUT = 2000;

	logic pllclk;
	logic reset;
	logic [NUM_INPUTS-1:0] samples;
	logic sample_strobe;
	delay_sel_t [NUM_INPUTS-1:0] delay_sel;
	integ_len_t integ_len;
	logic out_ack;
	logic out_req;
	logic [RESOLUTION-1:0] out_data;
	logic frame_dropped;

	int errors = 0;
	int checks = 0;
	int ack_delay = 1; // Cycles before the receiver raises out_ack
	int drop_count = 0;
	logic [31:0] lfsr = 32'h7a80_d818;
	logic [NUM_INPUTS-1:0] sample_hist[$]; // Every sample since reset, newest last
	logic [31:0] exp_words[$];
	logic [31:0] rx_words[$];
	int m_re[NB];
	int m_im[NB];
	logic [NB-1:0] m_ovf = '0;
	int m_cnt = 0;
	int m_len = 1;

	tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(16)) clk_gen (.pllclk(pllclk), .reset(reset));

	correlator_top #(
		.NUM_INPUTS(NUM_INPUTS),
		.RESOLUTION(RESOLUTION),
		.QUAD_LAG(QUAD_LAG)
	) dut (
		.pllclk(pllclk),
		.reset(reset),
		.samples(samples),
		.sample_strobe(sample_strobe),
		.delay_sel(delay_sel),
		.integ_len(integ_len),
		.out_ack(out_ack),
		.out_req(out_req),
		.out_data(out_data),
		.frame_dropped(frame_dropped)
	);

	// ========================================
	// Reference model
	// ========================================

	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	// Sample of input k from j strobes before the newest one
	function automatic logic past_bit(input int k, input int j);
		int idx;
		idx = sample_hist.size() - 1 - j;
		if (idx < 0) begin
			return 1'b0; // Nothing older than reset
		end
		return sample_hist[idx][k];
	endfunction

	function automatic void model_strobe(input logic [NUM_INPUTS-1:0] value);
		int k;
		logic [NUM_INPUTS-1:0] inph;
		logic [NUM_INPUTS-1:0] quad;
		logic [RESOLUTION-1:0] status;
		sample_hist.push_back(value);
		for (int n = 0; n < NUM_INPUTS; n++) begin
			inph[n] = past_bit(n, int'(delay_sel[n]));
			quad[n] = past_bit(n, int'(delay_sel[n]) + QUAD_LAG);
		end
		if (m_cnt == 0) begin
			m_len = (integ_len == '0) ? 1 : int'(integ_len);
		end
		k = 0;
		for (int a = 0; a < NUM_INPUTS - 1; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				if (inph[a] == inph[b]) begin
					if (m_re[k] == MAX_COUNT) m_ovf[k] = 1'b1;
					else m_re[k]++;
				end
				if (inph[a] == quad[b]) begin
					if (m_im[k] == MAX_COUNT) m_ovf[k] = 1'b1;
					else m_im[k]++;
				end
				k++;
			end
		end
		m_cnt++;
		if (m_cnt == m_len) begin
			status = '0;
			for (int i = 0; i < NB; i++) begin
				exp_words.push_back(32'(m_re[i]));
				exp_words.push_back(32'(m_im[i]));
				status[i] = m_ovf[i];
				m_re[i] = 0;
				m_im[i] = 0;
			end
			exp_words.push_back(32'(status)); // Overflow flags close the frame
			m_ovf = '0;
			m_cnt = 0;
		end
	endfunction

	// ========================================
	// Drivers, receiver and checks
	// ========================================

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR t=%0t %s: got %0h expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic set_config(input delay_sel_t [NUM_INPUTS-1:0] d, input int len);
		@(posedge pllclk);
		delay_sel <= d;
		integ_len <= integ_len_t'(len);
	endtask

	task automatic apply_strobe(input logic [NUM_INPUTS-1:0] value);
		@(posedge pllclk);
		samples <= value;
		sample_strobe <= 1'b1;
		model_strobe(value);
		@(posedge pllclk);
		sample_strobe <= 1'b0;
		@(posedge pllclk);
	endtask

	task automatic compare_frames(input string label);
		int cycles;
		cycles = 0;
		while (rx_words.size() < exp_words.size() && cycles < WORD_TIMEOUT) begin
			@(posedge pllclk);
			cycles++;
		end
		if (rx_words.size() < exp_words.size()) begin
			errors++;
			$display("Timeout in %s: only %0d of %0d frame words arrived", label,
				rx_words.size(), exp_words.size());
		end
		repeat (40) @(posedge pllclk); // Let any unexpected word show up
		check_value({label, " out_data word count"}, 32'(rx_words.size()),
			32'(exp_words.size()));
		for (int i = 0; i < exp_words.size() && i < rx_words.size(); i++) begin
			check_value($sformatf("%s out_data word %0d", label, i), rx_words[i], exp_words[i]);
		end
	endtask

	task automatic clear_frames();
		rx_words.delete();
		exp_words.delete();
	endtask

	initial begin
		logic [31:0] word;
		out_ack = 1'b0;
		forever begin
			@(posedge pllclk);
			if (out_req === 1'b1 && out_ack === 1'b0) begin
				word = 32'(out_data);
				repeat (ack_delay) @(posedge pllclk);
				out_ack <= 1'b1;
				@(posedge pllclk);
				while (out_req !== 1'b0) @(posedge pllclk);
				rx_words.push_back(word);
				out_ack <= 1'b0;
			end
		end
	end

	always @(posedge pllclk) begin
		if (frame_dropped === 1'b1) drop_count++;
	end

	// ========================================
	// Tests
	// ========================================

	task automatic test_idle_after_reset();
		repeat (10) begin
			@(posedge pllclk);
			check_value("out_req", 32'(out_req), 32'd0);
			check_value("frame_dropped", 32'(frame_dropped), 32'd0);
		end
	endtask

	task automatic test_constant_inputs();
		set_config('0, 20);
		for (int i = 0; i < 20; i++) begin
			check_value("out_req", 32'(out_req), 32'd0); // No frame before the first one ends
			check_value("frame_dropped", 32'(frame_dropped), 32'd0);
			apply_strobe('1);
		end
		compare_frames("constant frame");
		for (int k = 0; k < NB; k++) begin
			check_value($sformatf("out_data real total %0d", k), rx_words[2*k], 32'd20);
		end
		check_value("out_data status word", rx_words[2*NB], 32'd0);
		clear_frames();
	endtask

	task automatic test_random_frames();
		delay_sel_t [NUM_INPUTS-1:0] d;
		for (int k = 0; k < NUM_INPUTS; k++) begin
			d[k] = delay_sel_t'(rand_bits(DELAY_BITS));
		end
		set_config(d, 50);
		repeat (150) apply_strobe(NUM_INPUTS'(rand_bits(NUM_INPUTS)));
		compare_frames("random frames");
		clear_frames();
	endtask

	task automatic test_delay_compensation();
		logic [NUM_INPUTS-1:0] value;
		set_config({3'd0, 3'd0, 3'd0, 3'd3}, 40);
		repeat (40) begin
			value = NUM_INPUTS'(rand_bits(NUM_INPUTS));
			value[1] = past_bit(0, 2); // Input 0 three strobes before this one
			apply_strobe(value);
		end
		compare_frames("delay frame");
		check_value("out_data real total 0", rx_words[0], 32'd40);
		clear_frames();
	endtask

	task automatic test_overflow();
		logic [31:0] r;
		set_config('0, 300);
		repeat (300) begin
			r = rand_bits(3);
			apply_strobe({r[2:1], r[0], r[0]}); // Inputs 0 and 1 always agree
		end
		compare_frames("overflow frame");
		check_value("out_data real total 0", rx_words[0], 32'(MAX_COUNT));
		check_value("out_data status bit 0", 32'(rx_words[2*NB][0]), 32'd1);
		clear_frames();
		set_config('0, 20);
		repeat (20) begin
			r = rand_bits(3);
			apply_strobe({r[2:1], r[0], r[0]});
		end
		compare_frames("frame after overflow");
		check_value("out_data status bit 0", 32'(rx_words[2*NB][0]), 32'd0);
		clear_frames();
	endtask

	task automatic test_back_pressure();
		int drops_before;
		drops_before = drop_count;
		ack_delay = 20; // Slow receiver keeps the first frame busy
		set_config('0, 20);
		repeat (20) apply_strobe(NUM_INPUTS'(rand_bits(NUM_INPUTS)));
		repeat (20) apply_strobe(NUM_INPUTS'(rand_bits(NUM_INPUTS)));
		repeat (NUM_WORDS) begin
			void'(exp_words.pop_back()); // Second frame lands while the first is sent
		end
		set_config('0, 120);
		repeat (120) apply_strobe(NUM_INPUTS'(rand_bits(NUM_INPUTS)));
		compare_frames("back-pressure frames");
		check_value("frame_dropped pulses", 32'(drop_count - drops_before), 32'd1);
		clear_frames();
		ack_delay = 1;
	endtask

	initial begin
		repeat (TOTAL_STROBES * STROBE_GAP + SLACK_CYCLES) @(posedge pllclk);
		$display("Watchdog expired before the tests finished");
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		samples = '0;
		sample_strobe = 1'b0;
		delay_sel = '0;
		integ_len = '0;
		wait (reset === 1'b1);
		@(posedge pllclk);
		test_idle_after_reset();
		test_constant_inputs();
		test_random_frames();
		test_delay_compensation();
		test_overflow();
		test_back_pressure();
		check_value("total frame_dropped pulses", 32'(drop_count), 32'd1);
		$display("Correlator tests: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- correlator_top.f
corr_pkg.sv
sample_bus_if.sv
frame_if.sv
sample_delay_bank.sv
baseline_accumulator.sv
correlator_array.sv
frame_serializer.sv
correlator_top.sv
tb_clock_gen.sv
correlator_tb.sv

//--- Makefile
# Verilator lint and simulation of the correlator

VERILATOR ?= verilator
FILELIST ?= correlator_top.f
TB_TOP ?= correlator_tb
RTL_TOP ?= correlator_top
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails unless the pass line appears in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
